//--- src/gather_pkg.sv
package gather_pkg;

  // lane sample and store word
  localparam int SAMPLE_W       = 8;
  localparam int WORD_W         = 32;
  localparam int BYTES_PER_WORD = 4;
  // holds a release count of 0..4
  localparam int BYTE_CNT_W     = 3;

  // lanes and their ring regions in the store
  localparam int LANES_N    = 2;
  localparam int LANE_WORDS = 16;
  localparam int LANE_PTR_W = $clog2(LANE_WORDS);

  localparam int STORE_DEPTH  = 32;
  localparam int STORE_ADDR_W = 5;

  // host address map: 0x00..0x7c store words, 0x80 status / flush
  localparam int                  AXI_ADDR_W  = 8;
  localparam logic [AXI_ADDR_W-1:0] STATUS_ADDR = 8'h80;

  // per-lane word count, wraps
  localparam int COUNT_W = 8;

  // store requesters
  localparam int REQ_N     = 3;
  localparam int REQ_IDX_W = $clog2(REQ_N);
  localparam int REQ_LANE0 = 0;
  localparam int REQ_LANE1 = 1;
  localparam int REQ_HOST  = 2;

  // host read state encoding
  localparam int                  RD_STATE_W = 2;
  localparam logic [RD_STATE_W-1:0] RD_IDLE    = 2'd0;
  localparam logic [RD_STATE_W-1:0] RD_WAIT    = 2'd1;
  localparam logic [RD_STATE_W-1:0] RD_DATA    = 2'd2;
  localparam logic [RD_STATE_W-1:0] RD_HOLD    = 2'd3;

endpackage

//--- src/serial_in_parallel_out.sv
module serial_in_parallel_out #(
  parameter int els_p = 4
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   valid_i,
  input  logic [gather_pkg::SAMPLE_W-1:0]        data_i,
  output logic                                   ready_o,
  output logic [gather_pkg::BYTES_PER_WORD-1:0]  valid_o,
  output logic [gather_pkg::BYTES_PER_WORD-1:0][gather_pkg::SAMPLE_W-1:0] data_o,
  input  logic [gather_pkg::BYTE_CNT_W-1:0]      yumi_cnt_i
);
  import gather_pkg::*;

  logic [els_p-1:0][SAMPLE_W-1:0]   data_r;
  logic [els_p-1:0][SAMPLE_W-1:0]   data_nn;
  // double width so a shift by up to 4 never indexes past the end
  logic [2*els_p-1:0][SAMPLE_W-1:0] data_n;
  logic [els_p-1:0]                 valid_r;
  logic [els_p-1:0]                 valid_nn;
  logic [2*els_p-1:0]               valid_n;
  logic                             accept;
  int                               slot;

  // valid bits are always packed from slot 0, so the top slot tells full
  assign ready_o = ~valid_r[els_p-1];
  assign accept  = valid_i & ready_o;

  always_comb begin
    // first free slot, els_p when everything is occupied
    slot = els_p;
    for (int i = els_p - 1; i >= 0; i--) begin
      if (!valid_r[i]) begin
        slot = i;
      end
    end

    data_n             = '0;
    valid_n            = '0;
    data_n[els_p-1:0]  = data_r;
    valid_n[els_p-1:0] = valid_r;

    // bypass the arriving byte into the view
    data_n[slot]  = data_i;
    valid_n[slot] = accept;

    valid_o = valid_n[BYTES_PER_WORD-1:0];
    data_o  = data_n[BYTES_PER_WORD-1:0];

    // shift down by the number of bytes the packer takes
    for (int i = 0; i < els_p; i++) begin
      data_nn[i]  = data_n[yumi_cnt_i + i];
      valid_nn[i] = valid_n[yumi_cnt_i + i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= '0;
    end else begin
      valid_r <= valid_nn;
    end
  end

  // payload only, the valid vector qualifies it
  always_ff @(posedge clk_i) begin
    data_r <= data_nn;
  end

endmodule

//--- src/lane_packer.sv
module lane_packer #(
  parameter int lane_base = 0
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic [gather_pkg::BYTES_PER_WORD-1:0]  valid_i,
  input  logic [gather_pkg::BYTES_PER_WORD-1:0][gather_pkg::SAMPLE_W-1:0] data_i,
  output logic [gather_pkg::BYTE_CNT_W-1:0]      yumi_cnt_o,
  input  logic                                   flush_i,
  output logic                                   req_o,
  output logic [gather_pkg::STORE_ADDR_W-1:0]    addr_o,
  output logic [gather_pkg::WORD_W-1:0]          wdata_o,
  input  logic                                   gnt_i,
  output logic [gather_pkg::COUNT_W-1:0]         count_o
);
  import gather_pkg::*;

  // ring pointer inside this lane's region
  logic [LANE_PTR_W-1:0] ptr_r;
  logic [COUNT_W-1:0]    count_r;
  logic                  flush_r;
  logic [BYTE_CNT_W-1:0] nbytes;
  logic                  full;

  always_comb begin
    nbytes = '0;
    for (int i = 0; i < BYTES_PER_WORD; i++) begin
      if (valid_i[i]) begin
        nbytes = nbytes + 1'b1;
      end
      // little endian, missing bytes read as zero
      wdata_o[i*SAMPLE_W +: SAMPLE_W] = valid_i[i] ? data_i[i] : '0;
    end
  end

  assign full = &valid_i;

  // a partial word only goes out when a flush is pending
  // while waiting a flush word may pick up bytes that arrive late,
  // the count taken in the grant cycle always matches the data written
  assign req_o = full | (flush_r & valid_i[0]);

  // release only on the grant so the buffer holds still while waiting
  assign yumi_cnt_o = gnt_i ? nbytes : '0;

  assign addr_o  = STORE_ADDR_W'(lane_base) + STORE_ADDR_W'(ptr_r);
  assign count_o = count_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_r   <= '0;
      count_r <= '0;
      flush_r <= 1'b0;
    end else begin
      if (gnt_i) begin
        // ring wraps silently, older words are overwritten
        ptr_r   <= ptr_r + 1'b1;
        count_r <= count_r + 1'b1;
      end
      if (flush_i) begin
        flush_r <= 1'b1;
      end else if (gnt_i || !valid_i[0]) begin
        // done, or nothing to flush
        flush_r <= 1'b0;
      end
    end
  end

endmodule

//--- src/shared_word_store.sv
module shared_word_store (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic [gather_pkg::REQ_N-1:0]        req_i,
  input  logic [gather_pkg::REQ_N-1:0]        we_i,
  input  logic [gather_pkg::STORE_ADDR_W-1:0] addr0_i,
  input  logic [gather_pkg::STORE_ADDR_W-1:0] addr1_i,
  input  logic [gather_pkg::STORE_ADDR_W-1:0] addr2_i,
  input  logic [gather_pkg::WORD_W-1:0]       wdata0_i,
  input  logic [gather_pkg::WORD_W-1:0]       wdata1_i,
  output logic [gather_pkg::REQ_N-1:0]        gnt_o,
  output logic [gather_pkg::WORD_W-1:0]       rdata_o
);
  import gather_pkg::*;

  logic [WORD_W-1:0]       mem_r [STORE_DEPTH];
  logic [WORD_W-1:0]       rdata_r;
  // last winner, search starts one past it
  logic [REQ_IDX_W-1:0]    last_r;
  int                      win;
  int                      idx;
  logic                    any_gnt;
  logic                    we_sel;
  logic [STORE_ADDR_W-1:0] addr_sel;
  logic [WORD_W-1:0]       wdata_sel;

  // round robin, one-hot grant
  always_comb begin
    gnt_o   = '0;
    win     = 0;
    any_gnt = 1'b0;
    for (int k = 1; k <= REQ_N; k++) begin
      idx = (int'(last_r) + k) % REQ_N;
      if (!any_gnt && req_i[idx]) begin
        gnt_o[idx] = 1'b1;
        win        = idx;
        any_gnt    = 1'b1;
      end
    end
  end

  // single port, mux the winner onto it
  always_comb begin
    case (win)
      REQ_LANE0: addr_sel = addr0_i;
      REQ_LANE1: addr_sel = addr1_i;
      default:   addr_sel = addr2_i;
    endcase
  end

  // host never writes, so only lane data reaches the port
  assign wdata_sel = (win == REQ_LANE1) ? wdata1_i : wdata0_i;
  assign we_sel    = any_gnt & we_i[win];
  assign rdata_o   = rdata_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // lane 0 comes first after reset
      last_r <= REQ_IDX_W'(REQ_HOST);
    end else if (any_gnt) begin
      last_r <= REQ_IDX_W'(win);
    end
  end

  // write commits at the grant edge, read data shows up the cycle after
  always_ff @(posedge clk_i) begin
    if (we_sel) begin
      mem_r[addr_sel] <= wdata_sel;
    end
    if (any_gnt && !we_sel) begin
      rdata_r <= mem_r[addr_sel];
    end
  end

endmodule

//--- src/axil_host_port.sv
module axil_host_port (
  input  logic                                clk_i,
  input  logic                                reset_i,
  // write address / data
  input  logic [gather_pkg::AXI_ADDR_W-1:0]   awaddr_i,
  input  logic                                awvalid_i,
  output logic                                awready_o,
  input  logic [gather_pkg::WORD_W-1:0]       wdata_i,
  input  logic                                wvalid_i,
  output logic                                wready_o,
  output logic                                bvalid_o,
  input  logic                                bready_i,
  // read address / data
  input  logic [gather_pkg::AXI_ADDR_W-1:0]   araddr_i,
  input  logic                                arvalid_i,
  output logic                                arready_o,
  output logic [gather_pkg::WORD_W-1:0]       rdata_o,
  output logic                                rvalid_o,
  input  logic                                rready_i,
  // store requester
  output logic                                req_o,
  output logic [gather_pkg::STORE_ADDR_W-1:0] addr_o,
  input  logic                                gnt_i,
  input  logic [gather_pkg::WORD_W-1:0]       store_rdata_i,
  // status and flush
  input  logic [gather_pkg::COUNT_W-1:0]      count0_i,
  input  logic [gather_pkg::COUNT_W-1:0]      count1_i,
  output logic [gather_pkg::LANES_N-1:0]      flush_o
);
  import gather_pkg::*;

  logic [RD_STATE_W-1:0]   rd_state_r;
  logic [STORE_ADDR_W-1:0] rd_addr_r;
  logic [WORD_W-1:0]       rd_data_r;
  logic                    bvalid_r;
  logic [LANES_N-1:0]      flush_r;
  logic                    wr_acc;
  logic                    rd_acc;
  logic                    rd_status;
  logic [WORD_W-1:0]       status_word;

  // aw and w taken together, one response in flight at most
  assign wr_acc    = awvalid_i & wvalid_i & ~bvalid_r;
  assign awready_o = wr_acc;
  assign wready_o  = wr_acc;
  assign bvalid_o  = bvalid_r;
  assign flush_o   = flush_r;

  assign arready_o = (rd_state_r == RD_IDLE);
  assign rd_acc    = arvalid_i & arready_o;
  // top address bit picks status over the store window
  assign rd_status = araddr_i[AXI_ADDR_W-1];
  assign status_word = {{(WORD_W - 2*COUNT_W){1'b0}}, count1_i, count0_i};

  assign req_o  = (rd_state_r == RD_WAIT);
  assign addr_o = rd_addr_r;

  // first data beat comes straight from the store, later beats from the hold reg
  assign rvalid_o = (rd_state_r == RD_DATA) | (rd_state_r == RD_HOLD);
  assign rdata_o  = (rd_state_r == RD_DATA) ? store_rdata_i : rd_data_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_state_r <= RD_IDLE;
    end else begin
      case (rd_state_r)
        RD_IDLE: begin
          if (rd_acc) begin
            rd_state_r <= rd_status ? RD_HOLD : RD_WAIT;
          end
        end
        RD_WAIT: begin
          if (gnt_i) begin
            rd_state_r <= RD_DATA;
          end
        end
        RD_DATA: begin
          rd_state_r <= rready_i ? RD_IDLE : RD_HOLD;
        end
        default: begin
          if (rready_i) begin
            rd_state_r <= RD_IDLE;
          end
        end
      endcase
    end
  end

  // word address from the byte address
  always_ff @(posedge clk_i) begin
    if (rd_acc) begin
      rd_addr_r <= araddr_i[STORE_ADDR_W+1:2];
      rd_data_r <= status_word;
    end else if (rd_state_r == RD_DATA) begin
      rd_data_r <= store_rdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bvalid_r <= 1'b0;
      flush_r  <= '0;
    end else begin
      // flush is a single cycle strobe
      flush_r <= '0;
      if (wr_acc) begin
        bvalid_r <= 1'b1;
        if (awaddr_i == STATUS_ADDR) begin
          flush_r <= wdata_i[LANES_N-1:0];
        end
      end else if (bready_i) begin
        bvalid_r <= 1'b0;
      end
    end
  end

endmodule

//--- src/sample_gatherer_top.sv
module sample_gatherer_top (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              lane0_valid_i,
  input  logic [gather_pkg::SAMPLE_W-1:0]   lane0_data_i,
  output logic                              lane0_ready_o,
  input  logic                              lane1_valid_i,
  input  logic [gather_pkg::SAMPLE_W-1:0]   lane1_data_i,
  output logic                              lane1_ready_o,
  input  logic [gather_pkg::AXI_ADDR_W-1:0] awaddr_i,
  input  logic                              awvalid_i,
  output logic                              awready_o,
  input  logic [gather_pkg::WORD_W-1:0]     wdata_i,
  input  logic                              wvalid_i,
  output logic                              wready_o,
  output logic                              bvalid_o,
  input  logic                              bready_i,
  input  logic [gather_pkg::AXI_ADDR_W-1:0] araddr_i,
  input  logic                              arvalid_i,
  output logic                              arready_o,
  output logic [gather_pkg::WORD_W-1:0]     rdata_o,
  output logic                              rvalid_o,
  input  logic                              rready_i
);
  import gather_pkg::*;

  // buffer to packer, per lane
  logic [BYTES_PER_WORD-1:0]               sipo0_valid;
  logic [BYTES_PER_WORD-1:0][SAMPLE_W-1:0] sipo0_data;
  logic [BYTE_CNT_W-1:0]                   yumi0_cnt;
  logic [BYTES_PER_WORD-1:0]               sipo1_valid;
  logic [BYTES_PER_WORD-1:0][SAMPLE_W-1:0] sipo1_data;
  logic [BYTE_CNT_W-1:0]                   yumi1_cnt;

  // store requests
  logic                    pack0_req;
  logic                    pack1_req;
  logic                    host_req;
  logic [STORE_ADDR_W-1:0] pack0_addr;
  logic [STORE_ADDR_W-1:0] pack1_addr;
  logic [STORE_ADDR_W-1:0] host_addr;
  logic [WORD_W-1:0]       pack0_wdata;
  logic [WORD_W-1:0]       pack1_wdata;
  logic [REQ_N-1:0]        gnt;
  logic [WORD_W-1:0]       store_rdata;

  logic [COUNT_W-1:0] count0;
  logic [COUNT_W-1:0] count1;
  logic [LANES_N-1:0] flush;

  serial_in_parallel_out u_sipo0 (
    .clk_i, .reset_i,
    .valid_i(lane0_valid_i), .data_i(lane0_data_i), .ready_o(lane0_ready_o),
    .valid_o(sipo0_valid), .data_o(sipo0_data), .yumi_cnt_i(yumi0_cnt)
  );

  serial_in_parallel_out u_sipo1 (
    .clk_i, .reset_i,
    .valid_i(lane1_valid_i), .data_i(lane1_data_i), .ready_o(lane1_ready_o),
    .valid_o(sipo1_valid), .data_o(sipo1_data), .yumi_cnt_i(yumi1_cnt)
  );

  lane_packer #(.lane_base(0)) u_pack0 (
    .clk_i, .reset_i,
    .valid_i(sipo0_valid), .data_i(sipo0_data), .yumi_cnt_o(yumi0_cnt),
    .flush_i(flush[0]), .req_o(pack0_req), .addr_o(pack0_addr),
    .wdata_o(pack0_wdata), .gnt_i(gnt[REQ_LANE0]), .count_o(count0)
  );

  lane_packer #(.lane_base(LANE_WORDS)) u_pack1 (
    .clk_i, .reset_i,
    .valid_i(sipo1_valid), .data_i(sipo1_data), .yumi_cnt_o(yumi1_cnt),
    .flush_i(flush[1]), .req_o(pack1_req), .addr_o(pack1_addr),
    .wdata_o(pack1_wdata), .gnt_i(gnt[REQ_LANE1]), .count_o(count1)
  );

  // request order follows the requester indices, host is the only reader
  shared_word_store u_store (
    .clk_i, .reset_i,
    .req_i({host_req, pack1_req, pack0_req}),
    .we_i(3'b011),
    .addr0_i(pack0_addr), .addr1_i(pack1_addr), .addr2_i(host_addr),
    .wdata0_i(pack0_wdata), .wdata1_i(pack1_wdata),
    .gnt_o(gnt), .rdata_o(store_rdata)
  );

  axil_host_port u_host (
    .clk_i, .reset_i,
    .awaddr_i, .awvalid_i, .awready_o,
    .wdata_i, .wvalid_i, .wready_o,
    .bvalid_o, .bready_i,
    .araddr_i, .arvalid_i, .arready_o,
    .rdata_o, .rvalid_o, .rready_i,
    .req_o(host_req), .addr_o(host_addr), .gnt_i(gnt[REQ_HOST]),
    .store_rdata_i(store_rdata),
    .count0_i(count0), .count1_i(count1), .flush_o(flush)
  );

endmodule

//--- bench/gatherer_tb.sv
module gatherer_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import gather_pkg::*;

  // cycles any single wait may take
  localparam int WAIT_LIMIT  = 200;
  localparam int HOLD_CYCLES = 12;

  logic                  clk_i;
  logic                  reset_i;
  logic                  lane0_valid_i;
  logic [SAMPLE_W-1:0]   lane0_data_i;
  logic                  lane0_ready_o;
  logic                  lane1_valid_i;
  logic [SAMPLE_W-1:0]   lane1_data_i;
  logic                  lane1_ready_o;
  logic [AXI_ADDR_W-1:0] awaddr_i;
  logic                  awvalid_i;
  logic                  awready_o;
  logic [WORD_W-1:0]     wdata_i;
  logic                  wvalid_i;
  logic                  wready_o;
  logic                  bvalid_o;
  logic                  bready_i;
  logic [AXI_ADDR_W-1:0] araddr_i;
  logic                  arvalid_i;
  logic                  arready_o;
  logic [WORD_W-1:0]     rdata_o;
  logic                  rvalid_o;
  logic                  rready_i;

  int seed = 26;
  int errors;
  int checks;
  int test_start;
  logic done0;
  logic done1;

  // reference model of pending bytes and the expected store image and counts
  logic [SAMPLE_W-1:0] pend0[$];
  logic [SAMPLE_W-1:0] pend1[$];
  logic [WORD_W-1:0]   exp_mem [STORE_DEPTH];
  logic                exp_written [STORE_DEPTH];
  logic [COUNT_W-1:0]  exp_cnt [LANES_N];

  sample_gatherer_top sample_gatherer_top_i (
    .clk_i, .reset_i,
    .lane0_valid_i, .lane0_data_i, .lane0_ready_o,
    .lane1_valid_i, .lane1_data_i, .lane1_ready_o,
    .awaddr_i, .awvalid_i, .awready_o,
    .wdata_i, .wvalid_i, .wready_o,
    .bvalid_o, .bready_i,
    .araddr_i, .arvalid_i, .arready_o,
    .rdata_o, .rvalid_o, .rready_i
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      $display("** Error @ %0t ns: %s, got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
    errors++;
  endtask

  // byte 0 lands in bits 7:0 and missing bytes stay zero
  function automatic logic [WORD_W-1:0] pack_bytes(input logic [SAMPLE_W-1:0] q[$]);
    logic [WORD_W-1:0] w;
    w = '0;
    for (int i = 0; i < q.size(); i++) begin
      w[i*SAMPLE_W +: SAMPLE_W] = q[i];
    end
    return w;
  endfunction

  // word lands at the ring slot given by the count and overwrites older data
  task automatic store_word(input int lane, input logic [WORD_W-1:0] w);
    int idx;
    idx = lane * LANE_WORDS + int'(exp_cnt[lane]) % LANE_WORDS;
    exp_mem[idx]     = w;
    exp_written[idx] = 1'b1;
    exp_cnt[lane]    = exp_cnt[lane] + 1'b1;
  endtask

  task automatic model_push(input int lane, input logic [SAMPLE_W-1:0] b);
    if (lane == 0) begin
      pend0.push_back(b);
      if (pend0.size() == BYTES_PER_WORD) begin
        store_word(0, pack_bytes(pend0));
        pend0.delete();
      end
    end else begin
      pend1.push_back(b);
      if (pend1.size() == BYTES_PER_WORD) begin
        store_word(1, pack_bytes(pend1));
        pend1.delete();
      end
    end
  endtask

  // empty lane gives no word
  task automatic model_flush(input int lane);
    if (lane == 0 && pend0.size() > 0) begin
      store_word(0, pack_bytes(pend0));
      pend0.delete();
    end else if (lane == 1 && pend1.size() > 0) begin
      store_word(1, pack_bytes(pend1));
      pend1.delete();
    end
  endtask

  task automatic set_lane(input int lane, input logic v, input logic [SAMPLE_W-1:0] d);
    if (lane == 0) begin
      lane0_valid_i = v;
      lane0_data_i  = d;
    end else begin
      lane1_valid_i = v;
      lane1_data_i  = d;
    end
  endtask

  function automatic logic lane_ready(input int lane);
    return (lane == 0) ? lane0_ready_o : lane1_ready_o;
  endfunction

  // ready is a register output, so the value at the falling edge holds at the next rising edge
  task automatic drive_lane(input int lane, input int n);
    int gap;
    int t;
    logic [SAMPLE_W-1:0] b;
    for (int i = 0; i < n; i++) begin
      @(negedge clk_i);
      set_lane(lane, 1'b0, '0);
      gap = $random(seed) & 3;
      repeat (gap) @(negedge clk_i);
      t = 0;
      while (!lane_ready(lane) && t < WAIT_LIMIT) begin
        @(negedge clk_i);
        t++;
      end
      if (!lane_ready(lane)) begin
        report_timeout($sformatf("lane %0d ready", lane));
        return;
      end
      b = SAMPLE_W'($random(seed));
      set_lane(lane, 1'b1, b);
      model_push(lane, b);
    end
    @(negedge clk_i);
    set_lane(lane, 1'b0, '0);
  endtask

  task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
    int t;
    @(negedge clk_i);
    awaddr_i  = addr;
    awvalid_i = 1'b1;
    wdata_i   = data;
    wvalid_i  = 1'b1;
    bready_i  = 1'b1;
    // sample just after the edge once the inputs have settled
    #1;
    t = 0;
    while (!awready_o && t < WAIT_LIMIT) begin
      @(negedge clk_i);
      #1;
      t++;
    end
    if (!awready_o) begin
      report_timeout("write address accept");
    end else begin
      check_value(32'(wready_o), 32'd1, "wready together with awready");
    end
    @(negedge clk_i);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    #1;
    t = 0;
    while (!bvalid_o && t < WAIT_LIMIT) begin
      @(negedge clk_i);
      #1;
      t++;
    end
    if (!bvalid_o) begin
      report_timeout("write response");
    end
    @(negedge clk_i);
    bready_i = 1'b0;
  endtask

  // hold > 0 keeps rready low for that many cycles once data shows up
  task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, input int hold,
                          output logic [WORD_W-1:0] data);
    int t;
    data = '0;
    @(negedge clk_i);
    araddr_i  = addr;
    arvalid_i = 1'b1;
    rready_i  = (hold == 0);
    #1;
    t = 0;
    while (!arready_o && t < WAIT_LIMIT) begin
      @(negedge clk_i);
      #1;
      t++;
    end
    if (!arready_o) begin
      report_timeout("read address accept");
    end
    @(negedge clk_i);
    arvalid_i = 1'b0;
    #1;
    t = 0;
    while (!rvalid_o && t < WAIT_LIMIT) begin
      @(negedge clk_i);
      #1;
      t++;
    end
    if (!rvalid_o) begin
      report_timeout("read data valid");
      rready_i = 1'b0;
      return;
    end
    data = rdata_o;
    // data and valid must not move while the master stalls
    for (int i = 0; i < hold; i++) begin
      @(negedge clk_i);
      #1;
      check_value(32'(rvalid_o), 32'd1, "rvalid while held");
      check_value(rdata_o, data, "rdata while held");
    end
    rready_i = 1'b1;
    @(negedge clk_i);
    rready_i = 1'b0;
  endtask

  // poll until the counts reach the model and then compare
  task automatic wait_counts();
    logic [WORD_W-1:0] d;
    int t;
    t = 0;
    axi_read(STATUS_ADDR, 0, d);
    while (d[2*COUNT_W-1:0] != {exp_cnt[1], exp_cnt[0]} && t < WAIT_LIMIT) begin
      axi_read(STATUS_ADDR, 0, d);
      t++;
    end
    check_value(d, {16'h0, exp_cnt[1], exp_cnt[0]}, "status word counts");
  endtask

  task automatic check_region(input int lane);
    logic [WORD_W-1:0] d;
    int idx;
    for (int w = 0; w < LANE_WORDS; w++) begin
      idx = lane * LANE_WORDS + w;
      if (exp_written[idx]) begin
        axi_read(AXI_ADDR_W'(idx * 4), 0, d);
        check_value(d, exp_mem[idx], $sformatf("store word %0d", idx));
      end
    end
  endtask

  // host keeps reading status while both lanes stream
  task automatic poll_status();
    logic [WORD_W-1:0] d;
    int t;
    t = 0;
    while (!(done0 && done1) && t < WAIT_LIMIT) begin
      axi_read(STATUS_ADDR, 0, d);
      t++;
    end
    if (!(done0 && done1)) begin
      report_timeout("end of lane streams");
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %s done, %0d errors", name, errors - test_start);
    test_start = errors;
  endtask

  initial begin
    logic [WORD_W-1:0] d;
    int idx;
    reset_i       = 1'b1;
    lane0_valid_i = 1'b0;
    lane0_data_i  = '0;
    lane1_valid_i = 1'b0;
    lane1_data_i  = '0;
    awaddr_i      = '0;
    awvalid_i     = 1'b0;
    wdata_i       = '0;
    wvalid_i      = 1'b0;
    bready_i      = 1'b0;
    araddr_i      = '0;
    arvalid_i     = 1'b0;
    rready_i      = 1'b0;
    errors        = 0;
    checks        = 0;
    test_start    = 0;
    for (int i = 0; i < STORE_DEPTH; i++) begin
      exp_written[i] = 1'b0;
      exp_mem[i]     = '0;
    end
    exp_cnt[0] = '0;
    exp_cnt[1] = '0;
    repeat (4) @(negedge clk_i);
    reset_i = 1'b0;

    // idle state out of reset
    check_value(32'(lane0_ready_o), 32'd1, "lane 0 ready after reset");
    check_value(32'(lane1_ready_o), 32'd1, "lane 1 ready after reset");
    check_value(32'(rvalid_o), 32'd0, "rvalid after reset");
    check_value(32'(bvalid_o), 32'd0, "bvalid after reset");
    axi_read(STATUS_ADDR, 0, d);
    check_value(d, 32'h0, "status after reset");
    finish_test("reset");

    // two full words on lane 0
    drive_lane(0, 8);
    wait_counts();
    axi_read(STATUS_ADDR, 0, d);
    check_value(32'(d[COUNT_W-1:0]), 32'd2, "lane 0 word count");
    check_region(0);
    finish_test("lane0_words");

    // both lanes under arbitration with host traffic
    done0 = 1'b0;
    done1 = 1'b0;
    fork
      begin
        drive_lane(0, 16);
        done0 = 1'b1;
      end
      begin
        drive_lane(1, 16);
        done1 = 1'b1;
      end
      poll_status();
    join
    wait_counts();
    check_region(0);
    check_region(1);
    finish_test("two_lanes");

    // partial word on lane 1 and then a flush of an empty lane 0
    drive_lane(1, 3);
    axi_write(STATUS_ADDR, 32'h2);
    model_flush(1);
    wait_counts();
    idx = LANE_WORDS + (int'(exp_cnt[1]) + LANE_WORDS - 1) % LANE_WORDS;
    axi_read(AXI_ADDR_W'(idx * 4), 0, d);
    check_value(d, exp_mem[idx], "flushed word");
    check_value(32'(d[31:24]), 32'd0, "flushed word top byte");
    axi_write(STATUS_ADDR, 32'h1);
    model_flush(0);
    for (int i = 0; i < 3; i++) begin
      axi_read(STATUS_ADDR, 0, d);
      check_value(32'(d[COUNT_W-1:0]), 32'(exp_cnt[0]), "lane 0 count after empty flush");
    end
    finish_test("flush");

    // 18 more words wrap the lane 0 ring
    drive_lane(0, 18 * BYTES_PER_WORD);
    wait_counts();
    check_region(0);
    finish_test("ring_wrap");

    // lanes keep going under a stalled host read
    fork
      drive_lane(0, 16);
      drive_lane(1, 16);
      begin
        axi_read(8'h40, HOLD_CYCLES, d);
        check_value(d, exp_mem[LANE_WORDS], "held read data");
      end
    join
    wait_counts();
    check_region(0);
    check_region(1);
    finish_test("held_read");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- project.f
src/gather_pkg.sv
src/serial_in_parallel_out.sv
src/lane_packer.sv
src/shared_word_store.sv
src/axil_host_port.sv
src/sample_gatherer_top.sv
bench/gatherer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the gatherer testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module gatherer_tb \
  -o gatherer_sim \
  && ./obj_dir/gatherer_sim | tee sim.log \
  || { echo "build or run did not complete"; exit 1; }
grep -q "^sim passed$" sim.log \
  && exit 0 \
  || { echo "pass line not found in sim.log"; exit 1; }
